// ==== Bender.yml ====
package:
  name: cache_ctl

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cache_ctl_pkg.sv
      - hdl/cache_req_arb.sv
      - hdl/cache_ready.sv
      - hdl/cache_match_eval.sv
      - hdl/cache_ebox_seq.sv
      - hdl/cache_diag_mux.sv
      - hdl/cache_ctl.sv
  - target: simulation
    files:
      - verification/cache_ctl_asserts.sv
      - verification/cache_ctl_tb.sv

// ==== hdl/cache_ctl.sv ====
// Cache controller sequencing core top, connects arbiter, ready tracking, EBOX sequencer, diag
`timescale 1ns/10ps

module cache_ctl (
  input  logic                      clk,
  input  logic                      arst_n,
  input  cache_ctl_pkg::cache_req_t req,
  input  logic                      core_busy,
  input  logic                      cyc_done,
  input  logic                      core_data_valid,
  input  cache_ctl_pkg::ebox_ref_t  ebox_ref,
  input  logic                      page_ok,
  input  cache_ctl_pkg::way_info_t  ways,
  input  logic                      diag_en,
  input  cache_ctl_pkg::diag_sel_t  diag_sel,
  output cache_ctl_pkg::cache_req_t grant,
  output cache_ctl_pkg::cache_req_t cyc,
  output logic                      ready_to_go,
  output cache_ctl_pkg::ebox_resp_t ebox_resp,
  output cache_ctl_pkg::diag_byte_t diag_data
);

  logic                       done_pulse;
  cache_ctl_pkg::match_sum_t  match;
  cache_ctl_pkg::ebox_phase_e phase;

  cache_req_arb u_arb (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .core_busy   (core_busy),
    .ready_to_go (ready_to_go),
    .grant       (grant),
    .cyc         (cyc)
  );

  cache_ready u_ready (
    .clk         (clk),
    .arst_n      (arst_n),
    .cyc         (cyc),
    .grant       (grant),
    .cyc_done    (cyc_done),
    .done_pulse  (done_pulse),
    .ready_to_go (ready_to_go)
  );

  cache_match_eval u_match (
    .ways  (ways),
    .match (match)
  );

  cache_ebox_seq u_ebox (
    .clk             (clk),
    .arst_n          (arst_n),
    .ebox_start      (grant.ebox),
    .ebox_ref        (ebox_ref),
    .page_ok         (page_ok),
    .core_busy       (core_busy),
    .core_data_valid (core_data_valid),
    .match           (match),
    .resp            (ebox_resp),
    .done_pulse      (done_pulse),
    .phase           (phase)
  );

  cache_diag_mux u_diag (
    .diag_en     (diag_en),
    .diag_sel    (diag_sel),
    .cyc         (cyc),
    .ready_to_go (ready_to_go),
    .phase       (phase),
    .resp        (ebox_resp),
    .match       (match),
    .diag_data   (diag_data)
  );

endmodule

// ==== hdl/cache_ctl_config.svh ====
// Cache controller sizing and diagnostic group codes, included by the package and diag mux
`ifndef CACHE_CTL_CONFIG_SVH
`define CACHE_CTL_CONFIG_SVH

// Set-associative geometry
`define CSH_WAYS 4
`define CSH_LRU_W 2

// Diagnostic readback port
`define CSH_DIAG_SEL_W 3
`define CSH_DIAG_W 8

// Group codes on diag_sel
`define CSH_DIAG_CYC 3'd0
`define CSH_DIAG_PHASE 3'd1
`define CSH_DIAG_RESP 3'd2
`define CSH_DIAG_MATCH 3'd3

`endif

// ==== hdl/cache_ctl_pkg.sv ====
// Shared types of the cache controller core, referenced by scoped names from every module
`include "cache_ctl_config.svh"

package cache_ctl_pkg;

  typedef logic [`CSH_WAYS-1:0] way_vec_t;
  typedef logic [`CSH_LRU_W-1:0] lru_sel_t;
  typedef logic [`CSH_DIAG_SEL_W-1:0] diag_sel_t;
  typedef logic [`CSH_DIAG_W-1:0] diag_byte_t;

  // Requests, grants and cycle type share one layout
  typedef struct packed {
    logic mb;
    logic chan;
    logic ebox;
    logic cca;
  } cache_req_t;

  typedef struct packed {
    logic read;
    logic write;
    logic ac_ref;
    logic abort;
  } ebox_ref_t;

  // Directory lookup results, valid in T2
  typedef struct packed {
    way_vec_t valid_match;
    way_vec_t word_valid;
    way_vec_t written;
    lru_sel_t lru_sel;
  } way_info_t;

  typedef struct packed {
    logic any_valid;
    logic rd_found;
    logic lru_written;
    logic any_written;
  } match_sum_t;

  typedef struct packed {
    logic mbox_resp;
    logic retry_req;
    logic page_fail_hold;
    logic core_rd_rq;
    logic cache_wr;
  } ebox_resp_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_T0,
    PH_T1,
    PH_T2,
    PH_T3_WR,
    PH_T4_WR,
    PH_CORE_WAIT
  } ebox_phase_e;

endpackage

// ==== hdl/cache_diag_mux.sv ====
// Diagnostic readback mux, returns one group of controller state per select code
`timescale 1ns/10ps
`include "cache_ctl_config.svh"

module cache_diag_mux (
  input  logic                       diag_en,
  input  cache_ctl_pkg::diag_sel_t   diag_sel,
  input  cache_ctl_pkg::cache_req_t  cyc,
  input  logic                       ready_to_go,
  input  cache_ctl_pkg::ebox_phase_e phase,
  input  cache_ctl_pkg::ebox_resp_t  resp,
  input  cache_ctl_pkg::match_sum_t  match,
  output cache_ctl_pkg::diag_byte_t  diag_data
);

  // Groups pack from bit 0 upward, unused bits read zero
  always_comb begin
    diag_data = '0;
    if (diag_en) begin
      case (diag_sel)
        `CSH_DIAG_CYC: begin
          diag_data[4:0] = {ready_to_go, cyc.cca, cyc.ebox, cyc.chan, cyc.mb};
        end
        `CSH_DIAG_PHASE: begin
          diag_data[2:0] = phase;
        end
        `CSH_DIAG_RESP: begin
          diag_data[4:0] = {resp.cache_wr, resp.core_rd_rq, resp.page_fail_hold,
                            resp.retry_req, resp.mbox_resp};
        end
        `CSH_DIAG_MATCH: begin
          diag_data[3:0] = {match.any_written, match.lru_written,
                            match.rd_found, match.any_valid};
        end
        default: diag_data = '0;
      endcase
    end
  end

endmodule

// ==== hdl/cache_ebox_seq.sv ====
// EBOX reference sequencer, steps T0 to T2, picks the outcome and drives the response strobes
`timescale 1ns/10ps

module cache_ebox_seq (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        ebox_start,
  input  cache_ctl_pkg::ebox_ref_t    ebox_ref,
  input  logic                        page_ok,
  input  logic                        core_busy,
  input  logic                        core_data_valid,
  input  cache_ctl_pkg::match_sum_t   match,
  output cache_ctl_pkg::ebox_resp_t   resp,
  output logic                        done_pulse,
  output cache_ctl_pkg::ebox_phase_e  phase
);

  cache_ctl_pkg::ebox_phase_e phase_q;
  cache_ctl_pkg::ebox_phase_e phase_d;

  logic in_t2;
  logic t2_fail;
  logic t2_rd;
  logic t2_hit;
  logic t2_core;
  logic t2_rd_retry;
  logic t2_wr;
  logic t2_wb;
  logic t2_store;
  logic core_done;

  // T2 outcome, in priority order
  assign in_t2       = (phase_q == cache_ctl_pkg::PH_T2);
  assign t2_fail     = in_t2 & ~page_ok;
  assign t2_rd       = in_t2 & page_ok & ebox_ref.read;
  assign t2_hit      = t2_rd & match.rd_found;
  assign t2_core     = t2_rd & ~match.rd_found & ~core_busy;
  assign t2_rd_retry = t2_rd & ~match.rd_found & core_busy;
  assign t2_wr       = in_t2 & page_ok & ~ebox_ref.read & ebox_ref.write;
  assign t2_wb       = t2_wr & ~match.any_valid & match.lru_written;
  assign t2_store    = t2_wr & ~t2_wb;

  assign core_done = (phase_q == cache_ctl_pkg::PH_CORE_WAIT) & core_data_valid;

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      cache_ctl_pkg::PH_IDLE: begin
        if (ebox_start) begin
          phase_d = cache_ctl_pkg::PH_T0;
        end
      end
      cache_ctl_pkg::PH_T0: begin
        phase_d = ebox_ref.ac_ref ? cache_ctl_pkg::PH_IDLE : cache_ctl_pkg::PH_T1;
      end
      cache_ctl_pkg::PH_T1: begin
        phase_d = ebox_ref.abort ? cache_ctl_pkg::PH_IDLE : cache_ctl_pkg::PH_T2;
      end
      cache_ctl_pkg::PH_T2: begin
        if (t2_core) begin
          phase_d = cache_ctl_pkg::PH_CORE_WAIT;
        end else if (t2_store) begin
          phase_d = cache_ctl_pkg::PH_T3_WR;
        end else begin
          phase_d = cache_ctl_pkg::PH_IDLE;
        end
      end
      cache_ctl_pkg::PH_T3_WR:     phase_d = cache_ctl_pkg::PH_T4_WR;
      cache_ctl_pkg::PH_T4_WR:     phase_d = cache_ctl_pkg::PH_IDLE;
      cache_ctl_pkg::PH_CORE_WAIT: begin
        if (core_data_valid) begin
          phase_d = cache_ctl_pkg::PH_IDLE;
        end
      end
      default:                     phase_d = cache_ctl_pkg::PH_IDLE;
    endcase
  end

  // Finish terminates the reference, ready follows a clock later
  assign done_pulse = ((phase_q == cache_ctl_pkg::PH_T0) & ebox_ref.ac_ref) |
                      ((phase_q == cache_ctl_pkg::PH_T1) & ebox_ref.abort) |
                      (in_t2 & ~t2_core & ~t2_store) |
                      (phase_q == cache_ctl_pkg::PH_T4_WR) |
                      core_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase_q <= cache_ctl_pkg::PH_IDLE;
      resp    <= '0;
    end else begin
      phase_q             <= phase_d;
      resp.mbox_resp      <= t2_hit | core_done;
      resp.retry_req      <= t2_rd_retry | t2_wb;
      resp.cache_wr       <= t2_store;
      // Held until core data arrives
      resp.core_rd_rq     <= t2_core |
                             ((phase_q == cache_ctl_pkg::PH_CORE_WAIT) & ~core_data_valid);
      // Sticky until the EBOX is granted again
      resp.page_fail_hold <= t2_fail | (resp.page_fail_hold & ~ebox_start);
    end
  end

  assign phase = phase_q;

endmodule

// ==== hdl/cache_match_eval.sv ====
// Reduces the per-way directory status to the summary bits used by the EBOX sequencer
`timescale 1ns/10ps

module cache_match_eval (
  input  cache_ctl_pkg::way_info_t  ways,
  output cache_ctl_pkg::match_sum_t match
);

  cache_ctl_pkg::way_vec_t hit_words;
  cache_ctl_pkg::way_vec_t dirty_hits;

  assign hit_words  = ways.valid_match & ways.word_valid;
  assign dirty_hits = ways.valid_match & ways.written;

  assign match.any_valid   = |ways.valid_match;
  assign match.rd_found    = |hit_words;
  assign match.any_written = |dirty_hits;

  // Victim way is dirty, so a miss must write it back first
  assign match.lru_written = ways.written[ways.lru_sel];

endmodule

// ==== hdl/cache_ready.sv ====
// Idle tracking of the cache, drives the single ready_to_go level used by the arbiter
`timescale 1ns/10ps

module cache_ready (
  input  logic                      clk,
  input  logic                      arst_n,
  input  cache_ctl_pkg::cache_req_t cyc,
  input  cache_ctl_pkg::cache_req_t grant,
  input  logic                      cyc_done,
  input  logic                      done_pulse,
  output logic                      ready_to_go
);

  logic cache_idle;
  logic any_grant;
  logic non_ebox_done;
  logic complete;

  assign any_grant = |grant;

  // MB, channel and CCA cycles all end on the external done pulse
  assign non_ebox_done = cyc_done & (cyc.mb | cyc.chan | cyc.cca);

  assign complete = non_ebox_done | done_pulse | (ready_to_go & ~any_grant);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cache_idle <= 1'b1;
    end else if (any_grant) begin
      cache_idle <= 1'b0;
    end else if (complete) begin
      cache_idle <= 1'b1;
    end
  end

  assign ready_to_go = cache_idle;

endmodule

// ==== hdl/cache_req_arb.sv ====
// Fixed-priority request arbiter and cycle-type register, one instance in the controller top
`timescale 1ns/10ps

module cache_req_arb (
  input  logic                      clk,
  input  logic                      arst_n,
  input  cache_ctl_pkg::cache_req_t req,
  input  logic                      core_busy,
  input  logic                      ready_to_go,
  output cache_ctl_pkg::cache_req_t grant,
  output cache_ctl_pkg::cache_req_t cyc
);

  // Channel, EBOX and CCA may only start when core was free last clock
  logic req_en;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_en <= 1'b0;
    end else begin
      req_en <= ~core_busy;
    end
  end

  // MB > channel > EBOX > CCA
  // A raw request blocks every lower requester even when not enabled
  always_comb begin
    grant = '0;
    if (ready_to_go) begin
      if (req.mb) begin
        grant.mb = 1'b1;
      end else if (req.chan) begin
        grant.chan = req_en;
      end else if (req.ebox) begin
        grant.ebox = req_en;
      end else if (req.cca) begin
        grant.cca = req_en;
      end
    end
  end

  // Cycle type loads on every ready clock, all zero when nothing won
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc <= '0;
    end else if (ready_to_go) begin
      cyc <= grant;
    end
  end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/cache_ctl_pkg.sv
hdl/cache_req_arb.sv
hdl/cache_ready.sv
hdl/cache_match_eval.sv
hdl/cache_ebox_seq.sv
hdl/cache_diag_mux.sv
hdl/cache_ctl.sv
verification/cache_ctl_asserts.sv
verification/cache_ctl_tb.sv

// ==== verification/cache_ctl_asserts.sv ====
// Concurrent checks on grant and cycle encoding, bound into every cache_ctl instance
`timescale 1ns/10ps

module cache_ctl_asserts (
  input logic                      clk,
  input logic                      arst_n,
  input cache_ctl_pkg::cache_req_t grant,
  input cache_ctl_pkg::cache_req_t cyc,
  input logic                      ready_to_go,
  input cache_ctl_pkg::ebox_resp_t ebox_resp
);

  // Failed assertion count
  int fail_cnt = 0;

  a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
    else begin
      $error("More than one grant bit high");
      fail_cnt++;
    end

  a_cyc_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(cyc))
    else begin
      $error("Cycle type has more than one bit high");
      fail_cnt++;
    end

  // Arbiter only grants to an idle cache
  a_grant_ready: assert property (@(posedge clk) disable iff (!arst_n)
    (grant != '0) |-> ready_to_go)
    else begin
      $error("Grant issued while ready_to_go low");
      fail_cnt++;
    end

  a_mbox_in_ebox: assert property (@(posedge clk) disable iff (!arst_n)
    ebox_resp.mbox_resp |-> cyc.ebox)
    else begin
      $error("mbox_resp outside an EBOX cycle");
      fail_cnt++;
    end

endmodule

bind cache_ctl cache_ctl_asserts u_asserts (
  .clk         (clk),
  .arst_n      (arst_n),
  .grant       (grant),
  .cyc         (cyc),
  .ready_to_go (ready_to_go),
  .ebox_resp   (ebox_resp)
);

// ==== verification/cache_ctl_tb.sv ====
// Randomized testbench for the cache controller core, compares the DUT against a cycle model
`timescale 1ns/10ps
`include "cache_ctl_config.svh"

module cache_ctl_tb;

  localparam int NUM_CYCLES = 4000;
  localparam int DRAIN_TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'hdfd6_05fc;

  logic                       clk;
  logic                       arst_n;
  cache_ctl_pkg::cache_req_t  req;
  logic                       core_busy;
  logic                       cyc_done;
  logic                       core_data_valid;
  cache_ctl_pkg::ebox_ref_t   ebox_ref;
  logic                       page_ok;
  cache_ctl_pkg::way_info_t   ways;
  logic                       diag_en;
  cache_ctl_pkg::diag_sel_t   diag_sel;
  cache_ctl_pkg::cache_req_t  grant;
  cache_ctl_pkg::cache_req_t  cyc;
  logic                       ready_to_go;
  cache_ctl_pkg::ebox_resp_t  ebox_resp;
  cache_ctl_pkg::diag_byte_t  diag_data;

  // Reference model state
  logic                       m_req_en;
  cache_ctl_pkg::cache_req_t  m_cyc;
  logic                       m_idle;
  cache_ctl_pkg::ebox_phase_e m_phase;
  cache_ctl_pkg::ebox_resp_t  m_resp;

  logic [31:0] rng;
  int          cycle_no;
  int          waited;
  int          req_errs;
  int          resp_errs;
  int          ready_errs;
  int          diag_errs;
  int          assert_errs;
  int          other_errs;
  int          outcome_seen [0:7];

  cache_ctl UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .req             (req),
    .core_busy       (core_busy),
    .cyc_done        (cyc_done),
    .core_data_valid (core_data_valid),
    .ebox_ref        (ebox_ref),
    .page_ok         (page_ok),
    .ways            (ways),
    .diag_en         (diag_en),
    .diag_sel        (diag_sel),
    .grant           (grant),
    .cyc             (cyc),
    .ready_to_go     (ready_to_go),
    .ebox_resp       (ebox_resp),
    .diag_data       (diag_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return (r[31:16] % 100) < pct;
  endfunction

  function automatic cache_ctl_pkg::match_sum_t summarize(input cache_ctl_pkg::way_info_t w);
    cache_ctl_pkg::match_sum_t s;
    s.any_valid   = |w.valid_match;
    s.rd_found    = |(w.valid_match & w.word_valid);
    s.lru_written = w.written[w.lru_sel];
    s.any_written = |(w.valid_match & w.written);
    return s;
  endfunction

  // T2 outcome number in the order of the decision rules, 0 when neither read nor write
  function automatic int t2_outcome();
    cache_ctl_pkg::match_sum_t s;
    s = summarize(ways);
    if (!page_ok) begin
      return 1;
    end
    if (ebox_ref.read) begin
      if (s.rd_found) begin
        return 2;
      end
      return core_busy ? 4 : 3;
    end
    if (ebox_ref.write) begin
      return (!s.any_valid && s.lru_written) ? 5 : 6;
    end
    return 0;
  endfunction

  function automatic cache_ctl_pkg::cache_req_t model_grant();
    cache_ctl_pkg::cache_req_t g;
    g = '0;
    if (m_idle) begin
      if (req.mb) begin
        g.mb = 1'b1;
      end else if (req.chan || req.ebox || req.cca) begin
        // Lower requesters share one enable
        g.chan = req.chan & m_req_en;
        g.ebox = ~req.chan & req.ebox & m_req_en;
        g.cca  = ~req.chan & ~req.ebox & req.cca & m_req_en;
      end
    end
    return g;
  endfunction

  function automatic cache_ctl_pkg::diag_byte_t model_diag();
    cache_ctl_pkg::diag_byte_t d;
    cache_ctl_pkg::match_sum_t s;
    d = '0;
    s = summarize(ways);
    if (diag_en) begin
      case (diag_sel)
        `CSH_DIAG_CYC:   d = {3'b000, m_idle, m_cyc.cca, m_cyc.ebox, m_cyc.chan, m_cyc.mb};
        `CSH_DIAG_PHASE: d = {5'b00000, m_phase};
        `CSH_DIAG_RESP:  d = {3'b000, m_resp.cache_wr, m_resp.core_rd_rq,
                              m_resp.page_fail_hold, m_resp.retry_req, m_resp.mbox_resp};
        `CSH_DIAG_MATCH: d = {4'b0000, s.any_written, s.lru_written, s.rd_found, s.any_valid};
        default:         d = '0;
      endcase
    end
    return d;
  endfunction

  task automatic check_req(input string name, input cache_ctl_pkg::cache_req_t exp,
                           input cache_ctl_pkg::cache_req_t act);
    if (act !== exp) begin
      req_errs++;
      $display("FAIL %s cycle %0d: expected %b actual %b", name, cycle_no, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input cache_ctl_pkg::ebox_resp_t exp,
                            input cache_ctl_pkg::ebox_resp_t act);
    if (act !== exp) begin
      resp_errs++;
      $display("FAIL %s cycle %0d: expected %b actual %b", name, cycle_no, exp, act);
    end
  endtask

  task automatic check_diag(input string name, input cache_ctl_pkg::diag_byte_t exp,
                            input cache_ctl_pkg::diag_byte_t act);
    if (act !== exp) begin
      diag_errs++;
      $display("FAIL %s cycle %0d: expected %h actual %h", name, cycle_no, exp, act);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      ready_errs++;
      $display("FAIL %s cycle %0d: expected %b actual %b", name, cycle_no, exp, act);
    end
  endtask

  task automatic drive_inputs(input bit drain);
    logic [31:0] r;
    req.mb          = !drain && chance(15);
    req.chan        = !drain && chance(25);
    req.ebox        = !drain && chance(45);
    req.cca         = !drain && chance(25);
    core_busy       = chance(25);
    cyc_done        = chance(30);
    core_data_valid = chance(30);
    page_ok         = chance(85);
    // Qualifiers stay put while a reference is in flight
    if (m_phase == cache_ctl_pkg::PH_IDLE) begin
      ebox_ref.read   = chance(50);
      ebox_ref.write  = !ebox_ref.read || chance(10);
      ebox_ref.ac_ref = chance(12);
      ebox_ref.abort  = chance(12);
    end
    r = next_rand();
    ways = r[29:16];
    if (chance(35)) begin
      ways.valid_match = '0;
    end
    r = next_rand();
    diag_en  = r[31:24] > 8'd40;
    diag_sel = r[20:18];
  endtask

  // Advance the model by one clock, using the inputs held across the edge
  task automatic update_model();
    cache_ctl_pkg::cache_req_t  g;
    cache_ctl_pkg::ebox_phase_e nxt;
    cache_ctl_pkg::ebox_resp_t  r;
    int   outcome;
    logic done;
    logic complete;
    logic idle_nxt;
    g       = model_grant();
    outcome = t2_outcome();
    nxt     = m_phase;
    r       = '0;
    done    = 1'b0;
    case (m_phase)
      cache_ctl_pkg::PH_IDLE: begin
        if (g.ebox) begin
          nxt = cache_ctl_pkg::PH_T0;
        end
      end
      cache_ctl_pkg::PH_T0: begin
        done = ebox_ref.ac_ref;
        nxt  = done ? cache_ctl_pkg::PH_IDLE : cache_ctl_pkg::PH_T1;
      end
      cache_ctl_pkg::PH_T1: begin
        done = ebox_ref.abort;
        nxt  = done ? cache_ctl_pkg::PH_IDLE : cache_ctl_pkg::PH_T2;
      end
      cache_ctl_pkg::PH_T2: begin
        outcome_seen[outcome]++;
        r.page_fail_hold = (outcome == 1);
        r.mbox_resp      = (outcome == 2);
        r.core_rd_rq     = (outcome == 3);
        r.retry_req      = (outcome == 4) || (outcome == 5);
        r.cache_wr       = (outcome == 6);
        if (outcome == 3) begin
          nxt = cache_ctl_pkg::PH_CORE_WAIT;
        end else if (outcome == 6) begin
          nxt = cache_ctl_pkg::PH_T3_WR;
        end else begin
          nxt  = cache_ctl_pkg::PH_IDLE;
          done = 1'b1;
        end
      end
      cache_ctl_pkg::PH_T3_WR: nxt = cache_ctl_pkg::PH_T4_WR;
      cache_ctl_pkg::PH_T4_WR: begin
        nxt  = cache_ctl_pkg::PH_IDLE;
        done = 1'b1;
      end
      cache_ctl_pkg::PH_CORE_WAIT: begin
        done         = core_data_valid;
        r.mbox_resp  = core_data_valid;
        r.core_rd_rq = ~core_data_valid;
        nxt          = done ? cache_ctl_pkg::PH_IDLE : cache_ctl_pkg::PH_CORE_WAIT;
      end
      default: nxt = cache_ctl_pkg::PH_IDLE;
    endcase
    if ((m_phase == cache_ctl_pkg::PH_T0 || m_phase == cache_ctl_pkg::PH_T1) && done) begin
      outcome_seen[7]++;
    end
    r.page_fail_hold = r.page_fail_hold | (m_resp.page_fail_hold & ~g.ebox);
    complete = (cyc_done & (m_cyc.mb | m_cyc.chan | m_cyc.cca)) | done | (m_idle & (g == '0));
    idle_nxt = (g != '0) ? 1'b0 : (complete ? 1'b1 : m_idle);
    if (m_idle) begin
      m_cyc = g;
    end
    m_idle   = idle_nxt;
    m_req_en = ~core_busy;
    m_phase  = nxt;
    m_resp   = r;
  endtask

  // Runs from one falling edge to the next
  task automatic run_cycle(input bit drain);
    check_req("cyc", m_cyc, cyc);
    check_ready("ready_to_go", m_idle, ready_to_go);
    check_resp("ebox_resp", m_resp, ebox_resp);
    drive_inputs(drain);
    #1;
    check_req("grant", model_grant(), grant);
    check_diag("diag_data", model_diag(), diag_data);
    @(posedge clk);
    update_model();
    @(negedge clk);
  endtask

  initial begin
    rng             = SEED;
    clk             = 1'b0;
    arst_n          = 1'b0;
    req             = '0;
    core_busy       = 1'b0;
    cyc_done        = 1'b0;
    core_data_valid = 1'b0;
    ebox_ref        = '0;
    page_ok         = 1'b1;
    ways            = '0;
    diag_en         = 1'b0;
    diag_sel        = '0;
    req_errs        = 0;
    resp_errs       = 0;
    ready_errs      = 0;
    diag_errs       = 0;
    assert_errs     = 0;
    other_errs      = 0;
    for (int i = 0; i < 8; i++) begin
      outcome_seen[i] = 0;
    end
    m_req_en = 1'b0;
    m_cyc    = '0;
    m_idle   = 1'b1;
    m_phase  = cache_ctl_pkg::PH_IDLE;
    m_resp   = '0;

    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (cycle_no = 0; cycle_no < NUM_CYCLES; cycle_no++) begin
      run_cycle(1'b0);
    end

    // Requests stop, the controller must settle back to ready
    waited = 0;
    while (!(m_idle && ready_to_go) && waited < DRAIN_TIMEOUT) begin
      run_cycle(1'b1);
      waited++;
      cycle_no++;
    end
    if (!(m_idle && ready_to_go)) begin
      other_errs++;
      $display("Timeout: controller did not return to ready after requests stopped");
    end

    for (int i = 1; i < 8; i++) begin
      if (outcome_seen[i] == 0) begin
        other_errs++;
        $display("Stimulus never produced EBOX outcome %0d", i);
      end
    end

    assert_errs = UUT.u_asserts.fail_cnt;
    $display("Errors: req=%0d resp=%0d ready=%0d diag=%0d assert=%0d other=%0d",
             req_errs, resp_errs, ready_errs, diag_errs, assert_errs, other_errs);
    if (req_errs + resp_errs + ready_errs + diag_errs + assert_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
